//--- run_sim.sh
#!/usr/bin/env bash
# Builds the I2S capture testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_i2s_capture -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "=== FAIL ===" "$log_file"; then
	echo "Simulation reported a failure"
	exit 1
fi
exit 0

//--- source/drain_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface drain_bus_if
	import i2s_capture_pkg::*;
#(
	parameter int NUM_CHANNELS = 4,
	parameter int WORD_WIDTH   = word_width
);
	logic [NUM_CHANNELS-1:0]                 r_ready; // One bit per FIFO.
	logic [NUM_CHANNELS-1:0]                 r_enable;
	logic [NUM_CHANNELS-1:0][WORD_WIDTH-1:0] rdata; // Heads of all FIFOs.
	logic [id_width-1:0]                     grant_channel;

	modport scheduler (
		input  r_ready,
		output r_enable,
		output grant_channel
	);

	modport writer (
		input r_enable,
		input rdata,
		input grant_channel
	);

endinterface

`default_nettype wire

//--- source/drain_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module drain_scheduler
	import i2s_capture_pkg::*;
#(
	parameter int NUM_CHANNELS = 4,
	parameter int BURST_LEN    = 4
) (
	input logic            clk,
	input logic            rst_n,
	input logic            drain_enable,
	drain_bus_if.scheduler bus
);
	localparam int count_w = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
	localparam logic [id_width-1:0] last_channel = id_width'(NUM_CHANNELS - 1);
	localparam logic [count_w-1:0] last_read = count_w'(BURST_LEN - 1);

	sched_state_t            state;
	logic [id_width-1:0]     channel;
	logic [id_width-1:0]     next_channel;
	logic [count_w-1:0]      read_count;
	logic [NUM_CHANNELS-1:0] channel_sel;
	logic                    start_burst;

	assign next_channel = (channel == last_channel) ? '0 : channel + 1'b1;
	assign start_burst = drain_enable && |(bus.r_ready & channel_sel);
	assign bus.grant_channel = channel;

	always_comb begin
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			channel_sel[ch] = channel == id_width'(ch);
		end
	end

	always_comb begin
		bus.r_enable = '0;
		if (state == burst) begin
			bus.r_enable = channel_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= scan;
			channel    <= '0;
			read_count <= '0;
		end else begin
			case (state)
				scan: begin
					if (start_burst) begin
						state      <= burst;
						read_count <= '0;
					end else begin
						channel <= next_channel; // Not ready, try the next one.
					end
				end
				burst: begin
					read_count <= read_count + 1'b1;
					if (read_count == last_read) begin
						state <= advance;
					end
				end
				advance: begin
					// Idle cycle so the FIFO count settles before the next check.
					state   <= scan;
					channel <= next_channel;
				end
				default: begin
					state <= scan;
				end
			endcase
		end
	end

	// Only one FIFO is popped at a time.
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(bus.r_enable));

endmodule

`default_nettype wire

//--- source/i2s_capture_pkg.sv
`default_nettype none

package i2s_capture_pkg;

	// Each sample word carries the channel number, the slot and the 24-bit sample.
	localparam int sample_width = 24;
	localparam int word_width   = 32;
	localparam int id_width     = 5;
	localparam int id_lsb       = 27; // Channel number sits in bits 31 to 27.
	localparam int lr_bit       = 24; // High for the right slot.

	// Bits 26 and 25 stay zero.
	typedef logic [word_width-1:0] sample_word_t;

	typedef enum logic [1:0] {
		scan,
		burst,
		advance
	} sched_state_t;

endpackage

`default_nettype wire

//--- source/i2s_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_capture_top
	import i2s_capture_pkg::*;
#(
	parameter int NUM_CHANNELS = 4,
	parameter int FIFO_DEPTH   = 16,
	parameter int BURST_LEN    = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [NUM_CHANNELS-1:0] bclk,
	input  logic [NUM_CHANNELS-1:0] lrclk,
	input  logic [NUM_CHANNELS-1:0] sdata,
	input  logic                    drain_enable,
	output logic                    wen,
	output sample_word_t            wdata,
	output logic [NUM_CHANNELS-1:0] error_full
);
	drain_bus_if #(
		.NUM_CHANNELS(NUM_CHANNELS),
		.WORD_WIDTH  (word_width)
	) drain_bus ();

	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
		logic         sample_valid;
		sample_word_t sample;

		i2s_deserializer #(
			.CHANNEL_ID(ch)
		) i_deserializer (
			.clk         (clk),
			.rst_n       (rst_n),
			.bclk        (bclk[ch]),
			.lrclk       (lrclk[ch]),
			.sdata       (sdata[ch]),
			.sample_valid(sample_valid),
			.sample      (sample)
		);

		sample_fifo #(
			.FIFO_DEPTH(FIFO_DEPTH),
			.BURST_LEN (BURST_LEN)
		) i_fifo (
			.clk       (clk),
			.rst_n     (rst_n),
			.wr_valid  (sample_valid),
			.wr_data   (sample),
			.r_enable  (drain_bus.r_enable[ch]),
			.rdata     (drain_bus.rdata[ch]),
			.r_ready   (drain_bus.r_ready[ch]),
			.error_full(error_full[ch])
		);
	end

	drain_scheduler #(
		.NUM_CHANNELS(NUM_CHANNELS),
		.BURST_LEN   (BURST_LEN)
	) i_scheduler (
		.clk         (clk),
		.rst_n       (rst_n),
		.drain_enable(drain_enable),
		.bus         (drain_bus.scheduler)
	);

	word_writer #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) i_writer (
		.clk  (clk),
		.rst_n(rst_n),
		.bus  (drain_bus.writer),
		.wen  (wen),
		.wdata(wdata)
	);

endmodule

`default_nettype wire

//--- source/i2s_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_deserializer
	import i2s_capture_pkg::*;
#(
	parameter int CHANNEL_ID = 0
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         bclk,
	input  logic         lrclk,
	input  logic         sdata,
	output logic         sample_valid,
	output sample_word_t sample
);
	localparam int count_w = $clog2(sample_width);
	localparam logic [id_width-1:0] channel_tag = id_width'(CHANNEL_ID);
	localparam logic [count_w-1:0] last_bit = count_w'(sample_width - 1);

	logic [2:0]              bclk_sync; // Bit 2 is the previous synchronized value.
	logic [1:0]              lrclk_sync;
	logic [1:0]              sdata_sync;
	logic                    bclk_rise;
	logic                    lrclk_edge;
	logic                    shift_en;
	logic                    lrclk_last;
	logic                    slot_right;
	logic                    capturing;
	logic [count_w-1:0]      bit_count;
	logic [sample_width-1:0] shift_reg;

	assign bclk_rise  = bclk_sync[1] & ~bclk_sync[2];
	assign lrclk_edge = lrclk_sync[1] != lrclk_last;
	assign shift_en   = bclk_rise && capturing && !lrclk_edge;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bclk_sync    <= '0;
			lrclk_sync   <= '0;
			sdata_sync   <= '0;
			lrclk_last   <= 1'b0;
			slot_right   <= 1'b0;
			capturing    <= 1'b0;
			bit_count    <= '0;
			sample_valid <= 1'b0;
		end else begin
			bclk_sync    <= {bclk_sync[1:0], bclk};
			lrclk_sync   <= {lrclk_sync[0], lrclk};
			sdata_sync   <= {sdata_sync[0], sdata};
			sample_valid <= 1'b0;
			if (bclk_rise) begin
				lrclk_last <= lrclk_sync[1];
				if (lrclk_edge) begin
					// The MSB comes on the next bclk, this one still carries the old slot.
					slot_right <= lrclk_sync[1];
					capturing  <= 1'b1;
					bit_count  <= '0;
				end else if (capturing) begin
					bit_count <= bit_count + 1'b1;
					if (bit_count == last_bit) begin
						capturing    <= 1'b0;
						sample_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (shift_en) begin
			shift_reg <= {shift_reg[sample_width-2:0], sdata_sync[1]};
		end
	end

	always_comb begin
		sample = '0;
		sample[id_lsb +: id_width] = channel_tag;
		sample[lr_bit] = slot_right;
		sample[sample_width-1:0] = shift_reg;
	end

	// A slot yields one word, so the pulse never stretches.
	assert property (@(posedge clk) disable iff (!rst_n) sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

//--- source/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
	import i2s_capture_pkg::*;
#(
	parameter int FIFO_DEPTH = 16,
	parameter int BURST_LEN  = 4
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         wr_valid,
	input  sample_word_t wr_data,
	input  logic         r_enable,
	output sample_word_t rdata,
	output logic         r_ready,
	output logic         error_full
);
	localparam int addr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [addr_w:0] depth_count = (addr_w + 1)'(FIFO_DEPTH);
	localparam logic [addr_w:0] burst_count = (addr_w + 1)'(BURST_LEN);

	sample_word_t      mem [FIFO_DEPTH];
	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic [addr_w:0]   count;
	logic              full;
	logic              do_write;

	assign full     = count == depth_count;
	assign do_write = wr_valid && !full; // A read in the same cycle does not make room.
	assign rdata    = mem[rd_ptr];
	assign r_ready  = count >= burst_count;

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			error_full <= 1'b0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (r_enable) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, r_enable})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (wr_valid && full) begin
				error_full <= 1'b1; // Sticky until reset.
			end
		end
	end

	// The scheduler only starts a burst on a ready FIFO.
	assert property (@(posedge clk) disable iff (!rst_n) r_enable |-> count != '0);

endmodule

`default_nettype wire

//--- source/word_writer.sv
`timescale 1ns/1ps
`default_nettype none

module word_writer
	import i2s_capture_pkg::*;
#(
	parameter int NUM_CHANNELS = 4
) (
	input  logic         clk,
	input  logic         rst_n,
	drain_bus_if.writer  bus,
	output logic         wen,
	output sample_word_t wdata
);
	sample_word_t granted_word;
	logic         read_seen;

	assign read_seen = |bus.r_enable;

	// Head of the granted FIFO, valid during its read cycle.
	always_comb begin
		granted_word = '0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			if (bus.grant_channel == id_width'(ch)) begin
				granted_word = bus.rdata[ch];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wen   <= 1'b0;
			wdata <= '0;
		end else begin
			wen <= read_seen;
			if (read_seen) begin
				wdata <= granted_word; // Holds the last word between bursts.
			end
		end
	end

	// The tag written by the deserializer must match the channel the scheduler granted.
	assert property (@(posedge clk) disable iff (!rst_n)
		wen |-> wdata[id_lsb +: id_width] == $past(bus.grant_channel));

endmodule

`default_nettype wire

//--- sources.f
source/i2s_capture_pkg.sv
source/drain_bus_if.sv
source/i2s_deserializer.sv
source/sample_fifo.sv
source/drain_scheduler.sv
source/word_writer.sv
source/i2s_capture_top.sv
testbench/tb_i2s_transmitter.sv
testbench/tb_i2s_capture.sv

//--- testbench/tb_i2s_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2s_capture;
	localparam int num_channels   = 4;
	localparam int fifo_depth     = 16;
	localparam int burst_len      = 4;
	localparam int frames_a       = 10;
	localparam int frames_b       = 12;
	localparam int frame_cycles   = 512; // 64 bclk of 8 clk cycles.
	localparam int max_samples    = 2 * frames_b;
	localparam int timeout_cycles = 2 * (frames_a + frames_b) * frame_cycles + 2000;
	localparam int quiet_cycles   = num_channels * (burst_len + 2) + 16;
	localparam int drain_cycles   = (fifo_depth / burst_len) * quiet_cycles;
	localparam int seed           = 77154;

	logic                    clk;
	logic                    rst_n;
	logic                    drain_enable;
	wire  [num_channels-1:0] bclk;
	wire  [num_channels-1:0] lrclk;
	wire  [num_channels-1:0] sdata;
	logic                    wen;
	logic [31:0]             wdata;
	logic [num_channels-1:0] error_full;

	logic        tx_start;
	logic        phase_b;
	int          tx_frames;
	int          tx_offset [num_channels];
	int          tx_index [num_channels];
	int          tx_sent [num_channels];
	logic        tx_done [num_channels];
	logic [23:0] tx_sample [num_channels];
	logic [23:0] stim [num_channels][max_samples];

	// Reference model state, written only by the output monitor.
	logic [31:0] expected_q [num_channels][$];
	int          taken [num_channels];
	int          accepted [num_channels];
	int          popped [num_channels];
	int          run_len;
	logic [4:0]  run_id;
	int          data_errors = 0;
	int          burst_errors = 0;
	int          drop_errors = 0;
	int          wen_while_held = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	initial clk = 1'b0;
	always #5 clk = ~clk;

	i2s_capture_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.bclk        (bclk),
		.lrclk       (lrclk),
		.sdata       (sdata),
		.drain_enable(drain_enable),
		.wen         (wen),
		.wdata       (wdata),
		.error_full  (error_full)
	);

	for (genvar ch = 0; ch < num_channels; ch++) begin : g_tx
		assign tx_sample[ch] = stim[ch][tx_index[ch]];

		tb_i2s_transmitter i_tx (
			.clk         (clk),
			.start       (tx_start),
			.offset      (tx_offset[ch]),
			.num_frames  (tx_frames),
			.sample_value(tx_sample[ch]),
			.sample_index(tx_index[ch]),
			.sent_count  (tx_sent[ch]),
			.done        (tx_done[ch]),
			.bclk        (bclk[ch]),
			.lrclk       (lrclk[ch]),
			.sdata       (sdata[ch])
		);
	end

	// Even samples are left slots, odd samples right slots.
	function automatic logic [31:0] expected_word(input int ch, input int index);
		logic [31:0] word;
		word        = '0;
		word[31:27] = 5'(ch);
		word[24]    = index % 2 == 1;
		word[23:0]  = stim[ch][index];
		return word;
	endfunction

	task automatic start_phase(input int frames);
		for (int ch = 0; ch < num_channels; ch++) begin
			tx_offset[ch] = int'($urandom % 512);
			for (int i = 0; i < max_samples; i++) begin
				stim[ch][i] = 24'($urandom);
			end
		end
		tx_frames = frames;
		rst_n = 1'b0;
		repeat (10) @(negedge clk);
		rst_n    = 1'b1;
		tx_start = 1'b1;
	endtask

	task automatic wait_transmitters(input logic done_value);
		logic settled;
		settled = 1'b0;
		while (!settled) begin
			@(negedge clk);
			settled = 1'b1;
			for (int ch = 0; ch < num_channels; ch++) begin
				if (tx_done[ch] != done_value)
					settled = 1'b0;
			end
		end
	endtask

	task automatic wait_queues_below(input int limit, input int max_cycles);
		logic settled;
		int   cycles;
		settled = 1'b0;
		cycles  = 0;
		while (!settled && cycles < max_cycles) begin
			@(negedge clk);
			cycles++;
			settled = 1'b1;
			for (int ch = 0; ch < num_channels; ch++) begin
				if (expected_q[ch].size() >= limit)
					settled = 1'b0;
			end
		end
	endtask

	task automatic report_test(input string name, input int errors);
		if (errors == 0) begin
			$display("Test %s passed", name);
			tests_passed++;
		end else begin
			$display("Test %s failed with %0d errors", name, errors);
			tests_failed++;
		end
	endtask

	// Output monitor and reference model.
	always @(negedge clk) begin
		logic [31:0] head;
		int          id;
		if (!rst_n) begin
			for (int ch = 0; ch < num_channels; ch++) begin
				expected_q[ch].delete();
				taken[ch]    = 0;
				accepted[ch] = 0;
				popped[ch]   = 0;
			end
			run_len = 0;
		end else begin
			for (int ch = 0; ch < num_channels; ch++) begin
				if (tx_sent[ch] > taken[ch]) begin
					if (accepted[ch] - popped[ch] < fifo_depth) begin
						expected_q[ch].push_back(expected_word(ch, taken[ch]));
						accepted[ch]++;
					end
					taken[ch]++; // A sample at a full FIFO is dropped.
				end
			end
			if (wen) begin
				id = int'(wdata[31:27]);
				if (phase_b && !drain_enable)
					wen_while_held++;
				if (run_len > 0) begin
					assert (id == int'(run_id)) else begin
						$display("MISMATCH bursts: expected channel %0d actual %0d", run_id, id);
						burst_errors++;
					end
				end
				run_id = wdata[31:27];
				run_len++;
				if (id >= num_channels || expected_q[id].size() == 0) begin
					$display("Output word %08h arrived with no sample pending for its channel", wdata);
					if (phase_b)
						drop_errors++;
					else
						data_errors++;
				end else begin
					head = expected_q[id].pop_front();
					popped[id]++;
					assert (wdata == head) else begin
						$display("MISMATCH %s: expected %08h actual %08h",
							phase_b ? "drop_rule" : "data_integrity", head, wdata);
						if (phase_b)
							drop_errors++;
						else
							data_errors++;
					end
				end
			end else if (run_len > 0) begin
				assert (run_len == burst_len) else begin
					$display("MISMATCH bursts: expected run of %0d actual %0d", burst_len, run_len);
					burst_errors++;
				end
				run_len = 0;
			end
		end
	end

	initial begin
		int complete_errors;
		int held_errors;
		int drop_local;
		complete_errors = 0;
		held_errors     = 0;
		drop_local      = 0;
		void'($urandom(seed));
		rst_n        = 1'b0;
		drain_enable = 1'b1;
		tx_start     = 1'b0;
		phase_b      = 1'b0;
		tx_frames    = 0;
		start_phase(frames_a);
		wait_transmitters(1'b1);
		wait_queues_below(burst_len, drain_cycles);
		repeat (quiet_cycles) @(negedge clk);
		report_test("data_integrity", data_errors);
		for (int ch = 0; ch < num_channels; ch++) begin
			assert (expected_q[ch].size() < burst_len) else begin
				$display("MISMATCH completeness: channel %0d expected under %0d left, actual %0d",
					ch, burst_len, expected_q[ch].size());
				complete_errors++;
			end
			assert (popped[ch] + expected_q[ch].size() == 2 * frames_a) else begin
				$display("MISMATCH completeness: channel %0d expected %0d words, actual %0d",
					ch, 2 * frames_a, popped[ch] + expected_q[ch].size());
				complete_errors++;
			end
			assert (!error_full[ch]) else begin
				$display("MISMATCH completeness: channel %0d error_full expected 0 actual 1", ch);
				complete_errors++;
			end
		end
		report_test("completeness", complete_errors);
		tx_start = 1'b0;
		wait_transmitters(1'b0);

		phase_b      = 1'b1;
		drain_enable = 1'b0;
		start_phase(frames_b);
		wait_transmitters(1'b1);
		assert (wen_while_held == 0) else begin
			$display("MISMATCH back_pressure: expected 0 writes while held, actual %0d",
				wen_while_held);
			held_errors++;
		end
		for (int ch = 0; ch < num_channels; ch++) begin
			assert (error_full[ch]) else begin
				$display("MISMATCH back_pressure: channel %0d error_full expected 1 actual 0", ch);
				held_errors++;
			end
		end
		report_test("back_pressure", held_errors);
		drain_enable = 1'b1;
		wait_queues_below(1, drain_cycles);
		repeat (quiet_cycles) @(negedge clk);
		for (int ch = 0; ch < num_channels; ch++) begin
			assert (popped[ch] == fifo_depth) else begin
				$display("MISMATCH drop_rule: channel %0d expected %0d words, actual %0d",
					ch, fifo_depth, popped[ch]);
				drop_local++;
			end
		end
		report_test("drop_rule", drop_errors + drop_local);
		report_test("bursts", burst_errors);
		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_i2s_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2s_transmitter (
	input  logic        clk,
	input  logic        start,
	input  int          offset,
	input  int          num_frames,
	input  logic [23:0] sample_value,
	output int          sample_index,
	output int          sent_count,
	output logic        done,
	output logic        bclk,
	output logic        lrclk,
	output logic        sdata
);
	logic [23:0] word;
	int          slot_bit;

	// One bit lasts a full bclk period of 8 clk cycles.
	task automatic send_bit(input logic value, input logic count_sample);
		bclk  = 1'b0;
		sdata = value;
		if (count_sample) begin
			@(posedge clk);
			sent_count = sent_count + 1;
		end
		repeat (4) @(negedge clk);
		bclk = 1'b1;
		repeat (4) @(negedge clk);
	endtask

	initial begin
		bclk         = 1'b0;
		lrclk        = 1'b1;
		sdata        = 1'b0;
		done         = 1'b0;
		sample_index = 0;
		sent_count   = 0;
		word         = '0;
		forever begin
			while (!start) @(negedge clk);
			repeat (offset) @(negedge clk);
			lrclk = 1'b1;
			send_bit(1'b0, 1'b0); // Gives the receiver an lrclk edge before the first left slot.
			for (int frame = 0; frame < num_frames; frame++) begin
				for (int bit_pos = 0; bit_pos < 64; bit_pos++) begin
					slot_bit = bit_pos % 32;
					if (slot_bit == 0) begin
						lrclk        = bit_pos >= 32;
						sample_index = 2 * frame + bit_pos / 32;
					end
					if (slot_bit == 1) begin
						word = sample_value;
					end
					send_bit((slot_bit >= 1 && slot_bit <= 24) ? word[24 - slot_bit] : 1'b0,
						slot_bit == 25);
				end
			end
			done = 1'b1;
			while (start) @(negedge clk);
			done         = 1'b0;
			sent_count   = 0;
			sample_index = 0;
		end
	end

endmodule

`default_nettype wire
